//--- src/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// line geometry, shared by both caches
`define MEM_LINE_BYTES  32

// direct mapped, one line per set
`define MEM_NUM_SETS    8

`define MEM_BURST_BEATS 4    // 64-bit beats per line

`endif

//--- src/mem_types_pkg.sv
`include "mem_params.svh"

package mem_types_pkg;

    typedef logic [31:0]                                    word_t;
    typedef logic [3:0]                                     wmask_t;
    typedef logic [`MEM_LINE_BYTES*8-1:0]                   line_t;
    typedef logic [`MEM_LINE_BYTES-1:0]                     line_mask_t;  // one bit per byte
    typedef logic [`MEM_LINE_BYTES*8/`MEM_BURST_BEATS-1:0]  beat_t;

    // addr = {tag, set, offset}
    typedef logic [31-$clog2(`MEM_NUM_SETS)-$clog2(`MEM_LINE_BYTES):0] tag_t;
    typedef logic [$clog2(`MEM_NUM_SETS)-1:0]                          set_idx_t;

    typedef enum logic [1:0] {CS_IDLE, CS_COMPARE, CS_WRITEBACK, CS_FILL} cache_state_e;

    typedef enum logic [1:0] {AS_IDLE, AS_READ_BURST, AS_WRITE_BURST, AS_DONE} adaptor_state_e;

    typedef enum logic [1:0] {GNT_NONE, GNT_ICACHE, GNT_DCACHE} grant_e;

endpackage

//--- src/cacheline_if.sv
`timescale 1ns/1ps

// one 256-bit line transfer, strobe held until a one-cycle resp
interface cacheline_if;

    mem_types_pkg::word_t addr;    // line aligned
    logic                 read;
    logic                 write;
    mem_types_pkg::line_t wdata;
    mem_types_pkg::line_t rdata;   // valid with resp on a read
    logic                 resp;

    modport requester (
        output addr, read, write, wdata,
        input  rdata, resp
    );

    modport responder (
        input  addr, read, write, wdata,
        output rdata, resp
    );

endinterface

//--- src/word_adapter.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module word_adapter (
    input  mem_types_pkg::word_t      addr_i,
    input  mem_types_pkg::wmask_t     wmask_i,
    input  mem_types_pkg::word_t      wdata_i,
    input  mem_types_pkg::line_t      line_i,
    output mem_types_pkg::word_t      rdata_o,
    output mem_types_pkg::line_t      line_wdata_o,
    output mem_types_pkg::line_mask_t line_mask_o
);

    localparam int word_sel_w = $clog2(`MEM_LINE_BYTES / 4);

    logic [word_sel_w-1:0] word_sel;

    assign word_sel = addr_i[word_sel_w+1:2];    // word index inside the line

    assign rdata_o = line_i[word_sel*32 +: 32];

    // same word in every slot, the mask picks the live bytes
    assign line_wdata_o = {(`MEM_LINE_BYTES / 4){wdata_i}};

    assign line_mask_o = mem_types_pkg::line_mask_t'(wmask_i) << {word_sel, 2'b00};

endmodule

//--- src/line_cache.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module line_cache #(
    parameter bit read_only_p = 1'b0
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  mem_types_pkg::word_t  addr_i,
    input  logic                  read_i,
    input  logic                  write_i,
    input  mem_types_pkg::wmask_t wmask_i,
    input  mem_types_pkg::word_t  wdata_i,
    output mem_types_pkg::word_t  rdata_o,
    output logic                  resp_o,
    cacheline_if.requester        mem
);

    localparam int off_w = $clog2(`MEM_LINE_BYTES);
    localparam int idx_w = $clog2(`MEM_NUM_SETS);

    mem_types_pkg::cache_state_e state_q, state_d;

    mem_types_pkg::line_t data_q [`MEM_NUM_SETS];
    mem_types_pkg::tag_t  tag_q  [`MEM_NUM_SETS];
    logic [`MEM_NUM_SETS-1:0] valid_q;
    logic [`MEM_NUM_SETS-1:0] dirty_q;

    mem_types_pkg::set_idx_t   set;
    mem_types_pkg::tag_t       tag;
    mem_types_pkg::line_t      cur_line;
    mem_types_pkg::line_t      merged;
    mem_types_pkg::line_t      line_wdata;
    mem_types_pkg::line_mask_t line_mask;
    logic wr_req;
    logic hit;
    logic victim_dirty;
    logic fill_done;
    logic write_hit;

    assign set      = addr_i[off_w +: idx_w];
    assign tag      = addr_i[31 -: $bits(mem_types_pkg::tag_t)];
    assign wr_req   = !read_only_p && write_i;    // icache has no write path
    assign cur_line = data_q[set];
    assign hit      = valid_q[set] && (tag_q[set] == tag);

    assign victim_dirty = !read_only_p && valid_q[set] && dirty_q[set];
    assign fill_done    = (state_q == mem_types_pkg::CS_FILL) && mem.resp;
    assign write_hit    = (state_q == mem_types_pkg::CS_COMPARE) && hit && wr_req;

    word_adapter word_adapter_i (
        .addr_i       (addr_i),
        .wmask_i      (wmask_i),
        .wdata_i      (wdata_i),
        .line_i       (cur_line),
        .rdata_o      (rdata_o),
        .line_wdata_o (line_wdata),
        .line_mask_o  (line_mask)
    );

    // masked byte merge into the resident line
    always_comb begin
        merged = cur_line;
        for (int b = 0; b < `MEM_LINE_BYTES; b++) begin
            if (line_mask[b]) merged[b*8 +: 8] = line_wdata[b*8 +: 8];
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            mem_types_pkg::CS_IDLE: begin
                if (read_i || wr_req) state_d = mem_types_pkg::CS_COMPARE;
            end
            mem_types_pkg::CS_COMPARE: begin
                if (hit) state_d = mem_types_pkg::CS_IDLE;
                else if (victim_dirty) state_d = mem_types_pkg::CS_WRITEBACK;
                else state_d = mem_types_pkg::CS_FILL;
            end
            mem_types_pkg::CS_WRITEBACK: begin
                if (mem.resp) state_d = mem_types_pkg::CS_FILL;
            end
            mem_types_pkg::CS_FILL: begin
                if (mem.resp) state_d = mem_types_pkg::CS_COMPARE;    // finish as a hit
            end
            default: state_d = mem_types_pkg::CS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= mem_types_pkg::CS_IDLE;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            state_q <= state_d;
            if (fill_done) begin
                valid_q[set] <= 1'b1;
                dirty_q[set] <= 1'b0;
            end else if (write_hit) begin
                dirty_q[set] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            data_q[set] <= mem.rdata;
            tag_q[set]  <= tag;
        end else if (write_hit) begin
            data_q[set] <= merged;
        end
    end

    assign resp_o = (state_q == mem_types_pkg::CS_COMPARE) && hit;

    assign mem.read  = (state_q == mem_types_pkg::CS_FILL);
    assign mem.write = (state_q == mem_types_pkg::CS_WRITEBACK);
    assign mem.wdata = cur_line;    // victim line on writeback
    assign mem.addr  = (state_q == mem_types_pkg::CS_WRITEBACK)
                     ? {tag_q[set], set, {off_w{1'b0}}}
                     : {tag, set, {off_w{1'b0}}};

    a_cpu_rw_excl: assert property (@(posedge clk) disable iff (rst_i)
        !(read_i && write_i));

    // line request must not move before its resp
    a_mem_hold: assert property (@(posedge clk) disable iff (rst_i)
        (mem.read || mem.write) && !mem.resp
        |=> $stable(mem.read) && $stable(mem.write) && $stable(mem.addr));

endmodule

//--- src/cache_arbiter.sv
`timescale 1ns/1ps

module cache_arbiter (
    input  logic           clk,
    input  logic           rst_i,
    cacheline_if.responder icache,
    cacheline_if.responder dcache,
    cacheline_if.requester mem
);

    mem_types_pkg::grant_e grant_q;
    mem_types_pkg::grant_e owner;
    logic ic_req;
    logic dc_req;

    assign ic_req = icache.read || icache.write;
    assign dc_req = dcache.read || dcache.write;

    // new owner picked in the same cycle with dcache winning a tie
    always_comb begin
        owner = grant_q;
        if (grant_q == mem_types_pkg::GNT_NONE) begin
            if (dc_req) owner = mem_types_pkg::GNT_DCACHE;
            else if (ic_req) owner = mem_types_pkg::GNT_ICACHE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) grant_q <= mem_types_pkg::GNT_NONE;
        else if (mem.resp) grant_q <= mem_types_pkg::GNT_NONE;    // release after the line
        else grant_q <= owner;
    end

    always_comb begin
        mem.addr  = dcache.addr;
        mem.wdata = dcache.wdata;
        mem.read  = 1'b0;
        mem.write = 1'b0;
        case (owner)
            mem_types_pkg::GNT_ICACHE: begin
                mem.addr  = icache.addr;
                mem.wdata = icache.wdata;
                mem.read  = icache.read;
                mem.write = icache.write;
            end
            mem_types_pkg::GNT_DCACHE: begin
                mem.read  = dcache.read;
                mem.write = dcache.write;
            end
            default: ;
        endcase
    end

    assign icache.rdata = mem.rdata;
    assign dcache.rdata = mem.rdata;
    assign icache.resp  = mem.resp && (owner == mem_types_pkg::GNT_ICACHE);
    assign dcache.resp  = mem.resp && (owner == mem_types_pkg::GNT_DCACHE);

    // forwarded request and its owner stay put until the line resp
    a_grant_hold: assert property (@(posedge clk) disable iff (rst_i)
        (mem.read || mem.write) && !mem.resp
        |=> owner == $past(owner) && $stable(mem.addr) && (mem.read || mem.write));

    a_resp_owner: assert property (@(posedge clk) disable iff (rst_i)
        (!icache.resp || grant_q == mem_types_pkg::GNT_ICACHE) &&
        (!dcache.resp || grant_q == mem_types_pkg::GNT_DCACHE));

endmodule

//--- src/cacheline_adaptor.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module cacheline_adaptor (
    input  logic                  clk,
    input  logic                  rst_i,
    cacheline_if.responder        line,
    output mem_types_pkg::word_t  bmem_addr_o,
    output logic                  bmem_read_o,
    output logic                  bmem_write_o,
    output mem_types_pkg::beat_t  bmem_wdata_o,
    input  mem_types_pkg::beat_t  bmem_rdata_i,
    input  logic                  bmem_resp_i
);

    localparam int cnt_w  = $clog2(`MEM_BURST_BEATS);
    localparam int beat_w = $bits(mem_types_pkg::beat_t);
    localparam logic [cnt_w-1:0] last_beat = cnt_w'(`MEM_BURST_BEATS - 1);

    mem_types_pkg::adaptor_state_e state_q;
    logic [cnt_w-1:0]     beat_q;
    mem_types_pkg::word_t addr_q;
    mem_types_pkg::line_t line_q;    // write line or read line being assembled

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= mem_types_pkg::AS_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                mem_types_pkg::AS_IDLE: begin
                    beat_q <= '0;
                    if (line.read) state_q <= mem_types_pkg::AS_READ_BURST;
                    else if (line.write) state_q <= mem_types_pkg::AS_WRITE_BURST;
                end
                mem_types_pkg::AS_READ_BURST, mem_types_pkg::AS_WRITE_BURST: begin
                    if (bmem_resp_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (beat_q == last_beat) state_q <= mem_types_pkg::AS_DONE;
                    end
                end
                default: state_q <= mem_types_pkg::AS_IDLE;    // DONE lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == mem_types_pkg::AS_IDLE) begin
            addr_q <= line.addr;
            line_q <= line.wdata;
        end else if (state_q == mem_types_pkg::AS_READ_BURST && bmem_resp_i) begin
            line_q[beat_q*beat_w +: beat_w] <= bmem_rdata_i;    // beat 0 lowest
        end
    end

    assign bmem_addr_o  = addr_q;
    assign bmem_read_o  = (state_q == mem_types_pkg::AS_READ_BURST);
    assign bmem_write_o = (state_q == mem_types_pkg::AS_WRITE_BURST);
    assign bmem_wdata_o = line_q[beat_q*beat_w +: beat_w];

    assign line.rdata = line_q;
    assign line.resp  = (state_q == mem_types_pkg::AS_DONE);

    // burst direction comes from a single line strobe
    a_line_rw_excl: assert property (@(posedge clk) disable iff (rst_i)
        !(line.read && line.write));

endmodule

//--- src/mem_hierarchy.sv
`timescale 1ns/1ps

module mem_hierarchy (
    input  logic                  clk,
    input  logic                  rst_i,
    // instruction fetch
    input  mem_types_pkg::word_t  imem_addr_i,
    input  logic                  imem_read_i,
    output mem_types_pkg::word_t  imem_rdata_o,
    output logic                  imem_resp_o,
    // data load/store
    input  mem_types_pkg::word_t  dmem_addr_i,
    input  logic                  dmem_read_i,
    input  logic                  dmem_write_i,
    input  mem_types_pkg::wmask_t dmem_wmask_i,
    input  mem_types_pkg::word_t  dmem_wdata_i,
    output mem_types_pkg::word_t  dmem_rdata_o,
    output logic                  dmem_resp_o,
    // burst memory
    output mem_types_pkg::word_t  bmem_addr_o,
    output logic                  bmem_read_o,
    output logic                  bmem_write_o,
    output mem_types_pkg::beat_t  bmem_wdata_o,
    input  mem_types_pkg::beat_t  bmem_rdata_i,
    input  logic                  bmem_resp_i
);

    cacheline_if ic_line ();
    cacheline_if dc_line ();
    cacheline_if mem_line ();

    line_cache #(.read_only_p(1'b1)) icache (
        .clk     (clk),
        .rst_i   (rst_i),
        .addr_i  (imem_addr_i),
        .read_i  (imem_read_i),
        .write_i (1'b0),
        .wmask_i ('0),
        .wdata_i ('0),
        .rdata_o (imem_rdata_o),
        .resp_o  (imem_resp_o),
        .mem     (ic_line.requester)
    );

    line_cache #(.read_only_p(1'b0)) dcache (
        .clk     (clk),
        .rst_i   (rst_i),
        .addr_i  (dmem_addr_i),
        .read_i  (dmem_read_i),
        .write_i (dmem_write_i),
        .wmask_i (dmem_wmask_i),
        .wdata_i (dmem_wdata_i),
        .rdata_o (dmem_rdata_o),
        .resp_o  (dmem_resp_o),
        .mem     (dc_line.requester)
    );

    cache_arbiter arbiter (
        .clk    (clk),
        .rst_i  (rst_i),
        .icache (ic_line.responder),
        .dcache (dc_line.responder),
        .mem    (mem_line.requester)
    );

    cacheline_adaptor adaptor (
        .clk          (clk),
        .rst_i        (rst_i),
        .line         (mem_line.responder),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .bmem_write_o (bmem_write_o),
        .bmem_wdata_o (bmem_wdata_o),
        .bmem_rdata_i (bmem_rdata_i),
        .bmem_resp_i  (bmem_resp_i)
    );

endmodule

//--- test/burst_mem_model.sv
`timescale 1ns/1ps
`include "mem_params.svh"

// burst memory, words not yet written read as addr ^ 32'h5a5a_0000
module burst_mem_model #(
    parameter logic [31:0] seed_p = 32'h9c8
) (
    input  logic                 clk,
    input  logic                 rst_i,
    input  mem_types_pkg::word_t bmem_addr_i,
    input  logic                 bmem_read_i,
    input  logic                 bmem_write_i,
    input  mem_types_pkg::beat_t bmem_wdata_i,
    output mem_types_pkg::beat_t bmem_rdata_o,
    output logic                 bmem_resp_o
);

    mem_types_pkg::word_t store [mem_types_pkg::word_t];    // sparse, written words only
    logic [31:0] rng_state;

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic mem_types_pkg::word_t read_word(input mem_types_pkg::word_t a);
        mem_types_pkg::word_t w;
        if (store.exists(a)) w = store[a];
        else w = a ^ 32'h5a5a_0000;
        return w;
    endfunction

    initial begin
        mem_types_pkg::word_t base;
        logic is_write;
        int latency;
        rng_state = seed_p;
        bmem_resp_o = 1'b0;
        bmem_rdata_o = '0;
        forever begin
            @(negedge clk);
            if (!rst_i && (bmem_read_i || bmem_write_i)) begin
                base = bmem_addr_i;
                is_write = bmem_write_i;
                latency = int'(next_rand() % 6);    // 0 to 5 idle cycles
                repeat (latency) @(negedge clk);
                for (int k = 0; k < `MEM_BURST_BEATS; k++) begin
                    bmem_resp_o = 1'b1;
                    if (is_write) begin
                        store[base + 8 * k]     = bmem_wdata_i[31:0];
                        store[base + 8 * k + 4] = bmem_wdata_i[63:32];
                    end else begin
                        bmem_rdata_o = {read_word(base + 8 * k + 4), read_word(base + 8 * k)};
                    end
                    @(negedge clk);
                end
                bmem_resp_o = 1'b0;
            end
        end
    end

endmodule

//--- test/mem_hierarchy_tb.sv
`timescale 1ns/1ps

module mem_hierarchy_tb;

    localparam mem_types_pkg::word_t data_base = 32'h0000_4000;
    localparam mem_types_pkg::word_t inst_base = 32'h0010_0000;    // never written

    logic                  clk;
    logic                  rst_i;
    mem_types_pkg::word_t  imem_addr_i;
    logic                  imem_read_i;
    mem_types_pkg::word_t  imem_rdata_o;
    logic                  imem_resp_o;
    mem_types_pkg::word_t  dmem_addr_i;
    logic                  dmem_read_i;
    logic                  dmem_write_i;
    mem_types_pkg::wmask_t dmem_wmask_i;
    mem_types_pkg::word_t  dmem_wdata_i;
    mem_types_pkg::word_t  dmem_rdata_o;
    logic                  dmem_resp_o;
    mem_types_pkg::word_t  bmem_addr_o;
    logic                  bmem_read_o;
    logic                  bmem_write_o;
    mem_types_pkg::beat_t  bmem_wdata_o;
    mem_types_pkg::beat_t  bmem_rdata_i;
    logic                  bmem_resp_i;

    mem_types_pkg::word_t shadow [mem_types_pkg::word_t];
    mem_types_pkg::word_t exp_irdata;
    mem_types_pkg::word_t exp_drdata;
    logic [31:0] rng_state;
    logic        req_seen;    // first CPU request issued
    logic        burst_q;
    int          beats_seen;

    mem_hierarchy dut_i (.*);

    burst_mem_model mem_model_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .bmem_addr_i  (bmem_addr_o),
        .bmem_read_i  (bmem_read_o),
        .bmem_write_i (bmem_write_o),
        .bmem_wdata_i (bmem_wdata_o),
        .bmem_rdata_o (bmem_rdata_i),
        .bmem_resp_o  (bmem_resp_i)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // one of 64 lines above base so that sets collide
    function automatic mem_types_pkg::word_t pick_addr(input mem_types_pkg::word_t base);
        logic [31:0] r;
        r = next_rand();
        return base + {21'b0, r[10:2], 2'b00};
    endfunction

    function automatic mem_types_pkg::word_t expected_word(input mem_types_pkg::word_t a);
        mem_types_pkg::word_t w;
        if (shadow.exists(a)) w = shadow[a];
        else w = a ^ 32'h5a5a_0000;
        return w;
    endfunction

    function automatic mem_types_pkg::word_t merge_bytes(input mem_types_pkg::word_t old_w,
        input mem_types_pkg::word_t new_w, input mem_types_pkg::wmask_t m);
        mem_types_pkg::word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (m[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
        end
        return res;
    endfunction

    task automatic start_fetch(input mem_types_pkg::word_t a);
        req_seen = 1'b1;
        exp_irdata = expected_word(a);
        imem_addr_i = a;
        imem_read_i = 1'b1;
    endtask

    task automatic start_load(input mem_types_pkg::word_t a);
        req_seen = 1'b1;
        exp_drdata = expected_word(a);
        dmem_addr_i = a;
        dmem_read_i = 1'b1;
    endtask

    task automatic start_store(input mem_types_pkg::word_t a, input mem_types_pkg::wmask_t m,
        input mem_types_pkg::word_t d);
        req_seen = 1'b1;
        shadow[a] = merge_bytes(expected_word(a), d, m);
        dmem_addr_i = a;
        dmem_wmask_i = m;
        dmem_wdata_i = d;
        dmem_write_i = 1'b1;
    endtask

    // strobes drop in the cycle after their resp and one idle cycle follows
    task automatic wait_responses();
        int cycles;
        logic i_seen;
        logic d_seen;
        cycles = 0;
        i_seen = 1'b0;
        d_seen = 1'b0;
        while (imem_read_i || dmem_read_i || dmem_write_i) begin
            @(negedge clk);
            cycles++;
            if (i_seen) imem_read_i = 1'b0;
            if (d_seen) begin
                dmem_read_i = 1'b0;
                dmem_write_i = 1'b0;
            end
            i_seen = imem_resp_o;
            d_seen = dmem_resp_o;
            if (cycles > 200) report_failure("CPU response never arrived within 200 cycles");
        end
        @(negedge clk);
    endtask

    always_ff @(posedge clk) begin
        burst_q <= bmem_read_o || bmem_write_o;
        if (!(bmem_read_o || bmem_write_o)) beats_seen <= 0;
        else if (bmem_resp_i) beats_seen <= beats_seen + 1;
    end

    a_quiet_before_req: assert property (@(posedge clk) disable iff (rst_i)
        !req_seen |-> {imem_resp_o, dmem_resp_o, bmem_read_o, bmem_write_o} == 4'b0)
        else report_failure($sformatf("FAILED %s expected 0 got %h",
            "{imem_resp_o,dmem_resp_o,bmem_read_o,bmem_write_o}",
            $sampled({imem_resp_o, dmem_resp_o, bmem_read_o, bmem_write_o})));

    a_irdata: assert property (@(posedge clk) disable iff (rst_i)
        imem_resp_o |-> imem_rdata_o == exp_irdata)
        else report_failure($sformatf("FAILED imem_rdata_o expected %h got %h",
            $sampled(exp_irdata), $sampled(imem_rdata_o)));

    a_drdata: assert property (@(posedge clk) disable iff (rst_i)
        dmem_resp_o && dmem_read_i |-> dmem_rdata_o == exp_drdata)
        else report_failure($sformatf("FAILED dmem_rdata_o expected %h got %h",
            $sampled(exp_drdata), $sampled(dmem_rdata_o)));

    // a resp without a held strobe or two in a row means a duplicate
    a_iresp_pending: assert property (@(posedge clk) disable iff (rst_i)
        imem_resp_o |-> imem_read_i)
        else report_failure("imem_resp_o came with no fetch pending");

    a_dresp_pending: assert property (@(posedge clk) disable iff (rst_i)
        dmem_resp_o |-> dmem_read_i || dmem_write_i)
        else report_failure("dmem_resp_o came with no load or store pending");

    a_iresp_pulse: assert property (@(posedge clk) disable iff (rst_i)
        imem_resp_o |=> !imem_resp_o)
        else report_failure("FAILED imem_resp_o expected 0 got 1");

    a_dresp_pulse: assert property (@(posedge clk) disable iff (rst_i)
        dmem_resp_o |=> !dmem_resp_o)
        else report_failure("FAILED dmem_resp_o expected 0 got 1");

    a_burst_excl: assert property (@(posedge clk) disable iff (rst_i)
        !(bmem_read_o && bmem_write_o))
        else report_failure("FAILED bmem_read_o&bmem_write_o expected 0 got 1");

    a_burst_beats: assert property (@(posedge clk) disable iff (rst_i)
        burst_q && !(bmem_read_o || bmem_write_o) |-> beats_seen == 4)
        else report_failure($sformatf("FAILED beats_seen expected 4 got %h",
            $sampled(beats_seen)));

    initial begin
        mem_types_pkg::word_t a;
        logic [31:0] r;
        rst_i = 1'b1;
        imem_addr_i = '0;
        imem_read_i = 1'b0;
        dmem_addr_i = '0;
        dmem_read_i = 1'b0;
        dmem_write_i = 1'b0;
        dmem_wmask_i = '0;
        dmem_wdata_i = '0;
        rng_state = 32'h9c8;
        req_seen = 1'b0;
        exp_irdata = '0;
        exp_drdata = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        repeat (4) @(negedge clk);    // idle outputs stay low

        // unwritten words on both ports
        start_load(pick_addr(data_base));
        wait_responses();
        start_fetch(pick_addr(inst_base));
        wait_responses();

        a = pick_addr(data_base);
        start_store(a, 4'b0101, next_rand());
        wait_responses();
        start_load(a);
        wait_responses();

        // flipping tag bit 10 keeps the set and evicts the dirty line
        start_store(a, 4'b1110, next_rand());
        wait_responses();
        start_load(a ^ 32'h0000_0400);
        wait_responses();
        start_load(a);
        wait_responses();

        start_fetch(pick_addr(inst_base));
        start_load(pick_addr(data_base));
        wait_responses();

        repeat (400) begin
            r = next_rand();
            a = pick_addr(data_base);
            case (r[1:0])
                2'd0: start_load(a);
                2'd1: start_store(a, r[7:4], next_rand());
                2'd2: start_fetch(pick_addr(inst_base));
                default: begin
                    start_fetch(pick_addr(inst_base));
                    if (r[2]) start_store(a, r[7:4], next_rand());
                    else start_load(a);
                end
            endcase
            wait_responses();
        end

        $display("Regression passed");
        $finish;
    end

endmodule

//--- all.f
+incdir+src
src/mem_types_pkg.sv
src/cacheline_if.sv
src/word_adapter.sv
src/line_cache.sv
src/cache_arbiter.sv
src/cacheline_adaptor.sv
src/mem_hierarchy.sv
test/burst_mem_model.sv
test/mem_hierarchy_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the memory hierarchy testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module mem_hierarchy_tb \
    -f all.f \
    -o mem_hierarchy_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/mem_hierarchy_sim
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit "$sim_status"
fi
exit 0
